//--- logic/credit_cfg_pkg.sv
// Credit counting definitions
// Flow classes, slot indexing, counter and init-value types
// Scheduler phase encoding

package credit_cfg_pkg;

    // Flow classes in slot order
    typedef enum logic [1:0] {
        FC_POSTED     = 2'd0,
        FC_NONPOSTED  = 2'd1,
        FC_COMPLETION = 2'd2
    } flow_class_e;

    localparam int NUM_FC = 3;

    // One credit counter
    typedef logic [7:0] cnt_t;

    // Largest data chunk that a single return may carry
    localparam int MAX_DATA_PER_RETURN = 4;

    // Per-class initial credits
    typedef struct packed {
        cnt_t cpl;
        cnt_t np;
        cnt_t p;
    } hdr_slot_t;

    typedef struct packed {
        cnt_t cpl;
        cnt_t np;
        cnt_t p;
    } data_slot_t;

    typedef enum logic [1:0] {
        PH_IDLE = 2'd0,
        PH_WAIT = 2'd1,
        PH_INIT = 2'd2,
        PH_RUN  = 2'd3
    } sched_phase_e;

    // Slots are laid out channel major, three classes per channel
    function automatic int slot_idx(input logic [3:0] ch, input flow_class_e fc);
        return int'(ch) * NUM_FC + int'(fc);
    endfunction

endpackage

//--- logic/fabric_pkg.sv
// Fabric side signalling
// Credit event and credit return structs, agent ISM encoding

package fabric_pkg;

    typedef logic [3:0] chan_t;

    // Agent ISM ACTIVE state
    localparam logic [2:0] ISM_ACTIVE = 3'b011;

    // One credit event, from the fabric (consume) or the local queue (free)
    typedef struct packed {
        logic                       data_up;
        credit_cfg_pkg::cnt_t       data_amt;
        chan_t                      data_ch;
        credit_cfg_pkg::flow_class_e data_fc;
        logic                       hdr_up;
        chan_t                      hdr_ch;
        credit_cfg_pkg::flow_class_e hdr_fc;
    } credit_event_t;

    // One credit return toward the fabric
    typedef struct packed {
        logic                       put;
        chan_t                      ch;
        credit_cfg_pkg::flow_class_e fc;
        logic                       hdr;
        logic [2:0]                 data;
    } credit_return_t;

endpackage

//--- logic/credit_event_decoder.sv
// Credit event decoder
// Maps consume and free events onto per-slot increment and decrement vectors

`timescale 1ns/1ns

module credit_event_decoder
    import credit_cfg_pkg::*, fabric_pkg::*;
#(
    parameter int CHANNELS = 2,
    localparam int SLOTS = CHANNELS * NUM_FC
) (
    input  credit_event_t           consume_evt,
    input  credit_event_t           free_evt,

    output cnt_t [SLOTS-1:0]        inc_data,
    output cnt_t [SLOTS-1:0]        dec_data,
    output logic [SLOTS-1:0]        inc_hdr,
    output logic [SLOTS-1:0]        dec_hdr
);

    // True when a strobed event targets slot s
    function automatic logic slot_hit(
        input logic        up,
        input chan_t       ch,
        input flow_class_e fc,
        input int          s
    );
        return up && (slot_idx(ch, fc) == s);
    endfunction

    // ------------------------------------------------------------------
    // Frees from the local queue
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            inc_data[s] = '0;
            if (slot_hit(free_evt.data_up, free_evt.data_ch, free_evt.data_fc, s)) begin
                inc_data[s] = free_evt.data_amt;
            end
            inc_hdr[s] = slot_hit(free_evt.hdr_up, free_evt.hdr_ch, free_evt.hdr_fc, s);
        end
    end

    // ------------------------------------------------------------------
    // Consumes from the fabric
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            dec_data[s] = '0;
            if (slot_hit(consume_evt.data_up, consume_evt.data_ch,
                         consume_evt.data_fc, s)) begin
                dec_data[s] = consume_evt.data_amt;
            end
            dec_hdr[s] = slot_hit(consume_evt.hdr_up, consume_evt.hdr_ch,
                                  consume_evt.hdr_fc, s);
        end
    end

endmodule

//--- logic/credit_counter_bank.sv
// Credit counter bank
// Remaining and to-return counters per channel and flow class
// Unreturned-credits flag

`timescale 1ns/1ns

module credit_counter_bank
    import credit_cfg_pkg::*;
#(
    parameter int         CHANNELS  = 2,
    parameter hdr_slot_t  INIT_HDR  = '{p: 8'd6, np: 8'd4, cpl: 8'd6},
    parameter data_slot_t INIT_DATA = '{p: 8'd30, np: 8'd4, cpl: 8'd30},
    localparam int SLOTS = CHANNELS * NUM_FC,
    localparam int SEL_W = $clog2(SLOTS)
) (
    input  logic                    prim_nonflr_clk,
    input  logic                    prim_gated_rst_b,

    // From the scheduler
    input  logic                    load_init,
    input  logic                    running,
    input  logic [SEL_W-1:0]        sel_slot,
    input  logic [2:0]              ret_data,
    input  logic                    ret_hdr,

    // From the decoder
    input  cnt_t [SLOTS-1:0]        inc_data,
    input  cnt_t [SLOTS-1:0]        dec_data,
    input  logic [SLOTS-1:0]        inc_hdr,
    input  logic [SLOTS-1:0]        dec_hdr,

    output cnt_t [SLOTS-1:0]        ret_cnt_data,
    output cnt_t [SLOTS-1:0]        ret_cnt_hdr,
    output logic                    tgt_has_unret_credits
);

    cnt_t [SLOTS-1:0] init_data;
    cnt_t [SLOTS-1:0] init_hdr;

    cnt_t [SLOTS-1:0] rem_data;
    cnt_t [SLOTS-1:0] rem_hdr;
    cnt_t [SLOTS-1:0] rem_data_nxt;
    cnt_t [SLOTS-1:0] rem_hdr_nxt;

    cnt_t [SLOTS-1:0] tr_data;
    cnt_t [SLOTS-1:0] tr_hdr;
    cnt_t [SLOTS-1:0] tr_data_nxt;
    cnt_t [SLOTS-1:0] tr_hdr_nxt;

    logic             any_outstanding;

    // ------------------------------------------------------------------
    // Init values per slot, picked by flow class
    for (genvar s = 0; s < SLOTS; s++) begin : g_init
        localparam int FC = s % NUM_FC;

        assign init_data[s] = (FC == int'(FC_POSTED))    ? INIT_DATA.p  :
                              (FC == int'(FC_NONPOSTED)) ? INIT_DATA.np : INIT_DATA.cpl;
        assign init_hdr[s]  = (FC == int'(FC_POSTED))    ? INIT_HDR.p   :
                              (FC == int'(FC_NONPOSTED)) ? INIT_HDR.np  : INIT_HDR.cpl;
    end

    // ------------------------------------------------------------------
    // Next counter values
    always_comb begin
        cnt_t ret_d;
        cnt_t ret_h;

        for (int s = 0; s < SLOTS; s++) begin
            // Only the selected slot loses credits to a return
            ret_d = (int'(sel_slot) == s) ? cnt_t'(ret_data) : '0;
            ret_h = (int'(sel_slot) == s) ? cnt_t'(ret_hdr) : '0;

            rem_data_nxt[s] = rem_data[s];
            rem_hdr_nxt[s]  = rem_hdr[s];
            tr_data_nxt[s]  = tr_data[s] - ret_d;
            tr_hdr_nxt[s]   = tr_hdr[s] - ret_h;

            if (running) begin
                rem_data_nxt[s] = rem_data[s] + inc_data[s] - dec_data[s];
                rem_hdr_nxt[s]  = rem_hdr[s] + cnt_t'(inc_hdr[s]) - cnt_t'(dec_hdr[s]);
                tr_data_nxt[s]  = tr_data[s] + inc_data[s] - ret_d;
                tr_hdr_nxt[s]   = tr_hdr[s] + cnt_t'(inc_hdr[s]) - ret_h;
            end
        end
    end

    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            rem_data <= '0;
            rem_hdr  <= '0;
            tr_data  <= '0;
            tr_hdr   <= '0;
        end else if (load_init) begin
            rem_data <= init_data;
            rem_hdr  <= init_hdr;
            tr_data  <= init_data;
            tr_hdr   <= init_hdr;
        end else begin
            rem_data <= rem_data_nxt;
            rem_hdr  <= rem_hdr_nxt;
            tr_data  <= tr_data_nxt;
            tr_hdr   <= tr_hdr_nxt;
        end
    end

    // ------------------------------------------------------------------
    // Outstanding credits hold off the ISM idle request
    always_comb begin
        any_outstanding = 1'b0;
        for (int s = 0; s < SLOTS; s++) begin
            if (rem_data[s] != init_data[s] || rem_hdr[s] != init_hdr[s] ||
                tr_data[s] != '0 || tr_hdr[s] != '0) begin
                any_outstanding = 1'b1;
            end
        end
    end

    assign tgt_has_unret_credits = running & any_outstanding;
    assign ret_cnt_data          = tr_data;
    assign ret_cnt_hdr           = tr_hdr;

endmodule

//--- logic/credit_return_scheduler.sv
// Credit return scheduler
// Init advertise sequencer, round-robin return arbiter,
// ACTIVE gating and the registered credit return

`timescale 1ns/1ns

module credit_return_scheduler
    import credit_cfg_pkg::*, fabric_pkg::*;
#(
    parameter int CHANNELS = 2,
    localparam int SLOTS = CHANNELS * NUM_FC,
    localparam int SEL_W = $clog2(SLOTS)
) (
    input  logic                    prim_nonflr_clk,
    input  logic                    prim_gated_rst_b,

    input  logic                    credit_init,
    input  logic [2:0]              ism_agent,

    input  cnt_t [SLOTS-1:0]        ret_cnt_data,
    input  cnt_t [SLOTS-1:0]        ret_cnt_hdr,

    output logic                    load_init,
    output logic                    running,
    output logic [SEL_W-1:0]        sel_slot,
    output logic [2:0]              ret_data,
    output logic                    ret_hdr,

    output credit_return_t          credit_ret,
    output logic                    credit_init_in_progress,
    output logic                    credit_init_done
);

    sched_phase_e       phase;
    logic               init_q;
    logic               init_rise;
    logic               wait_cnt;
    logic [SEL_W-1:0]   init_ptr;
    logic               init_last;

    logic [SEL_W-1:0]   rr_ptr;
    logic [SEL_W-1:0]   rr_win;
    logic               rr_valid;

    logic               is_active;
    logic               ret_en;
    logic [SEL_W-1:0]   cand;
    cnt_t               cand_data;
    cnt_t               cand_hdr;
    logic               slot_empty;
    logic [2:0]         chunk_data;
    logic               go;

    credit_return_t     ret_nxt;
    credit_return_t     ret_q;

    assign is_active = (ism_agent == ISM_ACTIVE);
    // Return register advances during init or while ACTIVE
    assign ret_en    = credit_init | is_active;
    assign init_rise = credit_init & ~init_q;
    assign load_init = init_rise;
    assign running   = (phase == PH_RUN);
    assign init_last = (init_ptr == SEL_W'(SLOTS - 1));

    // ------------------------------------------------------------------
    // Round-robin search, starting one past the last winner
    always_comb begin
        int idx;

        rr_valid = 1'b0;
        rr_win   = rr_ptr;
        for (int off = 1; off <= SLOTS; off++) begin
            idx = int'(rr_ptr) + off;
            if (idx >= SLOTS) begin
                idx = idx - SLOTS;
            end
            if (!rr_valid && (ret_cnt_data[idx] != '0 || ret_cnt_hdr[idx] != '0)) begin
                rr_valid = 1'b1;
                rr_win   = SEL_W'(idx);
            end
        end
    end

    // ------------------------------------------------------------------
    // Chunk the selected slot
    assign cand       = (phase == PH_INIT) ? init_ptr : rr_win;
    assign cand_data  = ret_cnt_data[cand];
    assign cand_hdr   = ret_cnt_hdr[cand];
    assign slot_empty = (cand_data == '0) && (cand_hdr == '0);
    assign chunk_data = (cand_data >= cnt_t'(MAX_DATA_PER_RETURN)) ?
                        3'(MAX_DATA_PER_RETURN) : cand_data[2:0];

    assign go = ((phase == PH_INIT) && ret_en && !slot_empty) ||
                ((phase == PH_RUN) && is_active && rr_valid);

    assign sel_slot = cand;
    assign ret_data = go ? chunk_data : 3'd0;
    assign ret_hdr  = go & (cand_hdr != '0);

    // Channel and class of the selected slot
    always_comb begin
        ret_nxt      = '0;
        ret_nxt.put  = go;
        ret_nxt.hdr  = ret_hdr;
        ret_nxt.data = ret_data;
        for (int c = 0; c < CHANNELS; c++) begin
            for (int f = 0; f < NUM_FC; f++) begin
                if (slot_idx(4'(c), flow_class_e'(f)) == int'(cand)) begin
                    ret_nxt.ch = 4'(c);
                    ret_nxt.fc = flow_class_e'(f);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Phase FSM
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            phase    <= PH_IDLE;
            init_q   <= 1'b0;
            wait_cnt <= 1'b0;
            init_ptr <= '0;
            rr_ptr   <= SEL_W'(SLOTS - 1);
        end else begin
            init_q <= credit_init;
            if (init_rise) begin
                // Bank loads the init values on this edge
                phase    <= PH_WAIT;
                wait_cnt <= 1'b0;
                init_ptr <= '0;
                rr_ptr   <= SEL_W'(SLOTS - 1);
            end else begin
                case (phase)
                    PH_WAIT: begin
                        wait_cnt <= 1'b1;
                        if (wait_cnt) begin
                            phase <= PH_INIT;
                        end
                    end
                    PH_INIT: begin
                        // Slot fully advertised
                        if (slot_empty) begin
                            if (init_last) begin
                                phase <= PH_RUN;
                            end else begin
                                init_ptr <= init_ptr + SEL_W'(1);
                            end
                        end
                    end
                    PH_RUN: begin
                        if (go) begin
                            rr_ptr <= rr_win;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // ------------------------------------------------------------------
    // Return register and init flags
    always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
        if (!prim_gated_rst_b) begin
            ret_q                   <= '0;
            credit_init_in_progress <= 1'b1;
            credit_init_done        <= 1'b0;
        end else begin
            if (ret_en) begin
                ret_q <= ret_nxt;
            end
            credit_init_done        <= running & credit_init_in_progress;
            credit_init_in_progress <= ~running;
        end
    end

    // A held return reappears once gating lifts
    always_comb begin
        credit_ret     = ret_q;
        credit_ret.put = ret_q.put & ret_en;
    end

endmodule

//--- logic/tgt_credit_top.sv
// Target credit tracker top level
// Event decoder, counter bank and return scheduler

`timescale 1ns/1ns

module tgt_credit_top
    import credit_cfg_pkg::*, fabric_pkg::*;
#(
    parameter int         CHANNELS  = 2,
    parameter hdr_slot_t  INIT_HDR  = '{p: 8'd6, np: 8'd4, cpl: 8'd6},
    parameter data_slot_t INIT_DATA = '{p: 8'd30, np: 8'd4, cpl: 8'd30},
    localparam int SLOTS = CHANNELS * NUM_FC,
    localparam int SEL_W = $clog2(SLOTS)
) (
    input  logic                    prim_nonflr_clk,
    input  logic                    prim_gated_rst_b,

    input  logic [2:0]              ism_agent,
    input  logic                    credit_init,
    input  credit_event_t           consume_evt,
    input  credit_event_t           free_evt,

    output credit_return_t          credit_ret,
    output logic                    credit_init_in_progress,
    output logic                    credit_init_done,
    output logic                    tgt_has_unret_credits
);

    cnt_t [SLOTS-1:0]   inc_data;
    cnt_t [SLOTS-1:0]   dec_data;
    logic [SLOTS-1:0]   inc_hdr;
    logic [SLOTS-1:0]   dec_hdr;

    logic               load_init;
    logic               running;
    logic [SEL_W-1:0]   sel_slot;
    logic [2:0]         ret_data;
    logic               ret_hdr;

    cnt_t [SLOTS-1:0]   ret_cnt_data;
    cnt_t [SLOTS-1:0]   ret_cnt_hdr;

    credit_event_decoder #(
        .CHANNELS (CHANNELS)
    ) u_decoder (
        .consume_evt (consume_evt),
        .free_evt    (free_evt),
        .inc_data    (inc_data),
        .dec_data    (dec_data),
        .inc_hdr     (inc_hdr),
        .dec_hdr     (dec_hdr)
    );

    credit_counter_bank #(
        .CHANNELS  (CHANNELS),
        .INIT_HDR  (INIT_HDR),
        .INIT_DATA (INIT_DATA)
    ) u_bank (
        .prim_nonflr_clk       (prim_nonflr_clk),
        .prim_gated_rst_b      (prim_gated_rst_b),
        .load_init             (load_init),
        .running               (running),
        .sel_slot              (sel_slot),
        .ret_data              (ret_data),
        .ret_hdr               (ret_hdr),
        .inc_data              (inc_data),
        .dec_data              (dec_data),
        .inc_hdr               (inc_hdr),
        .dec_hdr               (dec_hdr),
        .ret_cnt_data          (ret_cnt_data),
        .ret_cnt_hdr           (ret_cnt_hdr),
        .tgt_has_unret_credits (tgt_has_unret_credits)
    );

    credit_return_scheduler #(
        .CHANNELS (CHANNELS)
    ) u_sched (
        .prim_nonflr_clk         (prim_nonflr_clk),
        .prim_gated_rst_b        (prim_gated_rst_b),
        .credit_init             (credit_init),
        .ism_agent               (ism_agent),
        .ret_cnt_data            (ret_cnt_data),
        .ret_cnt_hdr             (ret_cnt_hdr),
        .load_init               (load_init),
        .running                 (running),
        .sel_slot                (sel_slot),
        .ret_data                (ret_data),
        .ret_hdr                 (ret_hdr),
        .credit_ret              (credit_ret),
        .credit_init_in_progress (credit_init_in_progress),
        .credit_init_done        (credit_init_done)
    );

endmodule

//--- testbench/tb_tgt_credit.sv
// Testbench for the target credit tracker
// Clock and reset, LFSR stimulus, expected-total reference model,
// return monitor and watchdog

`timescale 1ns/1ns

module tb_tgt_credit
    import credit_cfg_pkg::*, fabric_pkg::*;
();

    localparam int         CHANNELS     = 2;
    localparam int         SLOTS        = CHANNELS * NUM_FC;
    localparam hdr_slot_t  INIT_HDR     = '{p: 8'd6, np: 8'd4, cpl: 8'd6};
    localparam data_slot_t INIT_DATA    = '{p: 8'd30, np: 8'd4, cpl: 8'd30};
    localparam int         CLK_PERIOD   = 10;
    localparam int         RESET_CYCLES = 8;
    localparam int         INIT_TIMEOUT = 300;
    localparam int         DRAIN_CYCLES = 200;
    localparam int         NUM_TXN      = 20;
    localparam int         GATED_TXN    = 8;
    // Worst case per transaction is well under 16 cycles
    localparam int         TEST_CYCLES  = RESET_CYCLES + INIT_TIMEOUT + 3 * DRAIN_CYCLES +
                                          (NUM_TXN + GATED_TXN + 2 * SLOTS) * 16;
    localparam int         WATCHDOG_NS  = (TEST_CYCLES + 200) * CLK_PERIOD;

    logic           prim_nonflr_clk = 1'b0;
    logic           prim_gated_rst_b;
    logic [2:0]     ism_agent;
    logic           credit_init;
    credit_event_t  consume_evt;
    credit_event_t  free_evt;
    credit_return_t credit_ret;
    logic           credit_init_in_progress;
    logic           credit_init_done;
    logic           tgt_has_unret_credits;

    logic [31:0]    lfsr = 32'h7b8e;
    int             freed_data [SLOTS] = '{default: 0};
    int             freed_hdr  [SLOTS] = '{default: 0};
    int             got_data   [SLOTS] = '{default: 0};
    int             got_hdr    [SLOTS] = '{default: 0};
    int             put_log [$];
    int             done_pulses    = 0;
    int             monitor_errors = 0;
    int             mismatches     = 0;
    int             failures       = 0;

    tgt_credit_top #(
        .CHANNELS  (CHANNELS),
        .INIT_HDR  (INIT_HDR),
        .INIT_DATA (INIT_DATA)
    ) dut_i (
        .prim_nonflr_clk         (prim_nonflr_clk),
        .prim_gated_rst_b        (prim_gated_rst_b),
        .ism_agent               (ism_agent),
        .credit_init             (credit_init),
        .consume_evt             (consume_evt),
        .free_evt                (free_evt),
        .credit_ret              (credit_ret),
        .credit_init_in_progress (credit_init_in_progress),
        .credit_init_done        (credit_init_done),
        .tgt_has_unret_credits   (tgt_has_unret_credits)
    );

    always #(CLK_PERIOD / 2) prim_nonflr_clk = ~prim_nonflr_clk;

    // ------------------------------------------------------------------
    // One LFSR step for each random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic int slot_of(input chan_t ch, input flow_class_e fc);
        return int'(ch) * NUM_FC + int'(fc);
    endfunction

    // Expected return total of a slot is its init credits plus all frees
    function automatic int expected_total(input int s, input bit is_hdr);
        int base;

        case (s % NUM_FC)
            0:       base = is_hdr ? int'(INIT_HDR.p)   : int'(INIT_DATA.p);
            1:       base = is_hdr ? int'(INIT_HDR.np)  : int'(INIT_DATA.np);
            default: base = is_hdr ? int'(INIT_HDR.cpl) : int'(INIT_DATA.cpl);
        endcase
        return base + (is_hdr ? freed_hdr[s] : freed_data[s]);
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        if (exp != act) begin
            mismatches++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_totals(input string name);
        for (int s = 0; s < SLOTS; s++) begin
            check_value($sformatf("%s slot %0d data", name, s),
                        expected_total(s, 1'b0), got_data[s]);
            check_value($sformatf("%s slot %0d hdr", name, s),
                        expected_total(s, 1'b1), got_hdr[s]);
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus helpers enter and leave just after a falling edge
    task automatic make_event(input int ds, input int amt, input int hs,
                              output credit_event_t ev);
        ev          = '0;
        ev.data_up  = 1'b1;
        ev.data_amt = cnt_t'(amt);
        ev.data_ch  = chan_t'(ds / NUM_FC);
        ev.data_fc  = flow_class_e'(2'(ds % NUM_FC));
        if (hs >= 0) begin
            ev.hdr_up = 1'b1;
            ev.hdr_ch = chan_t'(hs / NUM_FC);
            ev.hdr_fc = flow_class_e'(2'(hs % NUM_FC));
        end
    endtask

    task automatic random_event(output credit_event_t ev);
        int ds;
        int amt;
        int has_hdr;
        int hs;

        draw(3, ds);
        draw(2, amt);
        draw(1, has_hdr);
        draw(3, hs);
        make_event(ds % SLOTS, amt + 1, (has_hdr != 0) ? hs % SLOTS : -1, ev);
    endtask

    // Hold both events for one cycle and book the frees
    task automatic apply(input credit_event_t cons, input credit_event_t fr);
        consume_evt = cons;
        free_evt    = fr;
        if (fr.data_up) begin
            freed_data[slot_of(fr.data_ch, fr.data_fc)] += int'(fr.data_amt);
        end
        if (fr.hdr_up) begin
            freed_hdr[slot_of(fr.hdr_ch, fr.hdr_fc)] += 1;
        end
        @(negedge prim_nonflr_clk);
        consume_evt = '0;
        free_evt    = '0;
    endtask

    task automatic consume_then_free(input string name, input credit_event_t ev, input int gap);
        apply(ev, '0);
        check_value({name, " unret flag after consume"}, 1, int'(tgt_has_unret_credits));
        repeat (gap) @(negedge prim_nonflr_clk);
        apply('0, ev);
    endtask

    // Wait for every credit to come back before comparing the totals
    task automatic drain(input string name);
        int n;

        n = 0;
        while (tgt_has_unret_credits && n < DRAIN_CYCLES) begin
            @(negedge prim_nonflr_clk);
            n++;
        end
        if (tgt_has_unret_credits) begin
            failures++;
            $display("%s: credits still outstanding after %0d cycles", name, DRAIN_CYCLES);
        end
        repeat (3) @(negedge prim_nonflr_clk);
        compare_totals(name);
    endtask

    // ------------------------------------------------------------------
    // Return monitor
    always @(posedge prim_nonflr_clk) begin : monitor
        int s;

        if (credit_ret.put) begin
            s = slot_of(credit_ret.ch, credit_ret.fc);
            if (credit_ret.data > 3'd4) begin
                monitor_errors++;
                $display("MISMATCH chunk size: expected at most 4, actual %0d",
                         credit_ret.data);
            end
            if (!credit_init && ism_agent != ISM_ACTIVE) begin
                monitor_errors++;
                $display("Return put while ism_agent is not ACTIVE and credit_init is low");
            end
            if (s >= SLOTS) begin
                monitor_errors++;
                $display("Return names channel %0d, which does not exist", credit_ret.ch);
            end else begin
                got_data[s] += int'(credit_ret.data);
                got_hdr[s]  += int'(credit_ret.hdr);
                put_log.push_back(s);
            end
        end
        if (credit_init_done) begin
            done_pulses++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    // ------------------------------------------------------------------
    initial begin : stimulus
        credit_event_t ev;
        credit_event_t rr_evt [SLOTS];
        int            n;
        int            gap;
        int            pause;
        int            snap;
        int            mask;

        prim_gated_rst_b = 1'b0;
        ism_agent        = 3'b000;
        credit_init      = 1'b0;
        consume_evt      = '0;
        free_evt         = '0;
        repeat (RESET_CYCLES) @(posedge prim_nonflr_clk);
        @(negedge prim_nonflr_clk);
        prim_gated_rst_b = 1'b1;
        @(negedge prim_nonflr_clk);

        // Reset values
        check_value("reset put", 0, int'(credit_ret.put));
        check_value("reset init_done", 0, int'(credit_init_done));
        check_value("reset unret flag", 0, int'(tgt_has_unret_credits));
        check_value("reset in_progress", 1, int'(credit_init_in_progress));

        // Init advertise
        ism_agent   = ISM_ACTIVE;
        credit_init = 1'b1;
        n = 0;
        while (!credit_init_done && n < INIT_TIMEOUT) begin
            @(negedge prim_nonflr_clk);
            n++;
        end
        if (!credit_init_done) begin
            failures++;
            $display("init: credit_init_done did not pulse within %0d cycles", INIT_TIMEOUT);
        end
        repeat (4) @(negedge prim_nonflr_clk);
        check_value("init done pulses", 1, done_pulses);
        check_value("init in_progress", 0, int'(credit_init_in_progress));
        compare_totals("init");
        credit_init = 1'b0;

        // Gating leaves every slot pending before ACTIVE resumes
        ism_agent = 3'b001;
        snap = put_log.size();
        for (int t = 0; t < GATED_TXN; t++) begin
            random_event(ev);
            consume_then_free("gating", ev, 0);
        end
        for (int s = 0; s < SLOTS; s++) begin
            make_event(s, 1 + s % 4, (s + 2) % SLOTS, ev);
            consume_then_free("gating", ev, 0);
        end
        check_value("gating puts while not ACTIVE", snap, put_log.size());
        check_value("gating unret flag", 1, int'(tgt_has_unret_credits));
        ism_agent = ISM_ACTIVE;
        drain("gating");

        // Round-robin serves each pending slot once before any repeat
        mask = 0;
        if (put_log.size() < snap + SLOTS) begin
            failures++;
            $display("round_robin: fewer than %0d returns after ACTIVE resumed", SLOTS);
        end else begin
            for (int i = 0; i < SLOTS; i++) begin
                mask |= 1 << put_log[snap + i];
            end
        end
        check_value("round_robin first slots mask", (1 << SLOTS) - 1, mask);

        // Running traffic with random pauses of ACTIVE
        for (int t = 0; t < NUM_TXN; t++) begin
            random_event(ev);
            draw(2, gap);
            consume_then_free("running", ev, gap);
            draw(1, pause);
            if (pause != 0) begin
                draw(3, gap);
                ism_agent = 3'b001;
                repeat (gap + 1) @(negedge prim_nonflr_clk);
                ism_agent = ISM_ACTIVE;
            end
        end
        drain("running");

        // Frees on two slots per cycle across the whole bank
        for (int s = 0; s < SLOTS; s++) begin
            make_event(s, 4 - s % 4, SLOTS - 1 - s, rr_evt[s]);
            apply(rr_evt[s], '0);
        end
        for (int s = 0; s < SLOTS; s++) begin
            apply('0, rr_evt[s]);
        end
        drain("round_robin");

        // A single init strobe gives a single done pulse over the whole run
        check_value("done pulses over the run", 1, done_pulses);

        $display("Checks done: %0d mismatches, %0d failures, %0d monitor errors",
                 mismatches, failures, monitor_errors);
        if (mismatches == 0 && failures == 0 && monitor_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- all.f
logic/credit_cfg_pkg.sv
logic/fabric_pkg.sv
logic/credit_event_decoder.sv
logic/credit_counter_bank.sv
logic/credit_return_scheduler.sv
logic/tgt_credit_top.sv
testbench/tb_tgt_credit.sv

//--- Makefile
# Verilator build and run for the target credit tracker testbench
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_tgt_credit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || \
		(echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
